// File: verilog.f
+incdir+include
hdl/runner_pkg.sv
hdl/game_ctrl_if.sv
hdl/game_fsm.sv
hdl/box_collider.sv
hdl/speed_ctrl.sv
hdl/night_mode.sv
hdl/runner_top.sv
testbench/tb_clock_gen.sv
testbench/runner_assertions.sv
testbench/tb_runner.sv

// File: Makefile
# Verilator build for the runner game core

TOP := tb_runner

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module runner_top

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: testbench/tb_runner.sv
`timescale 1ns/100ps
`include "runner_defs.svh"

module tb_runner;
    import runner_pkg::*;

    localparam int FRAME_CYCLES   = 4;
    localparam int TEST_FRAMES    = `CLEAR_TIME + `INVERT_FADE_DURATION + 100;
    localparam int TIMEOUT_CYCLES = FRAME_CYCLES * TEST_FRAMES + 1000;

    logic           clk;
    logic           rst;
    logic           jumping;
    logic           painter_finished;
    logic           invert_trigger;
    collision_box_t trex_boxes     [`TREX_BOX_COUNT];
    collision_box_t obstacle_boxes [`OBSTACLE_BOX_COUNT];
    game_state_t    state;
    speed_t         speed;
    logic           has_obstacles;
    logic [7:0]     night_rate;

    int   seed        = 32'h0511_85c8;
    int   cycle_count = 0;
    int   phase       = 0;
    logic frames_on   = 1'b0;
    int   pass_tests  = 0;
    int   fail_tests  = 0;
    int   fails_before;
    bit   wait_failed;

    tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(3)) i_clock_gen (.clk(clk), .rst(rst));

    runner_top i_dut (
        .clk              (clk),
        .rst              (rst),
        .jumping          (jumping),
        .painter_finished (painter_finished),
        .invert_trigger   (invert_trigger),
        .trex_boxes       (trex_boxes),
        .obstacle_boxes   (obstacle_boxes),
        .state            (state),
        .speed            (speed),
        .has_obstacles    (has_obstacles),
        .night_rate       (night_rate)
    );

    bind runner_top runner_assertions i_runner_assertions (
        .clk              (clk),
        .rst              (rst),
        .jumping          (jumping),
        .painter_finished (painter_finished),
        .invert_trigger   (invert_trigger),
        .trex_boxes       (trex_boxes),
        .obstacle_boxes   (obstacle_boxes),
        .state            (state),
        .speed            (speed),
        .has_obstacles    (has_obstacles),
        .night_rate       (night_rate)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // painter_finished pulses on the first cycle of every four
    task automatic tick();
        @(negedge clk);
        painter_finished = frames_on && (phase == 0);
        phase = (phase + 1) % FRAME_CYCLES;
    endtask

    task automatic run_frames(input int n);
        repeat (n * FRAME_CYCLES) tick();
    endtask

    task automatic wait_state(input game_state_t target, input int max_cycles);
        int waited;
        waited = 0;
        while (state != target && waited < max_cycles) begin
            tick();
            waited++;
        end
        if (state != target) begin
            $display("state %s not reached within %0d cycles at %0t",
                target.name(), max_cycles, $time);
            wait_failed = 1'b1;
        end
    endtask

    // T-Rex boxes end left of x 1800, obstacles start at x 2000
    task automatic draw_disjoint_boxes();
        for (int i = 0; i < `TREX_BOX_COUNT; i++) begin
            trex_boxes[i].x = 12'($unsigned($random(seed)) % 800);
            trex_boxes[i].y = 12'($unsigned($random(seed)) % 3000);
            trex_boxes[i].w = 12'(1 + $unsigned($random(seed)) % 1000);
            trex_boxes[i].h = 12'(1 + $unsigned($random(seed)) % 1000);
        end
        for (int i = 0; i < `OBSTACLE_BOX_COUNT; i++) begin
            obstacle_boxes[i].x = 12'(2000 + $unsigned($random(seed)) % 800);
            obstacle_boxes[i].y = 12'($unsigned($random(seed)) % 3000);
            obstacle_boxes[i].w = 12'(1 + $unsigned($random(seed)) % 1000);
            obstacle_boxes[i].h = 12'(1 + $unsigned($random(seed)) % 1000);
        end
    endtask

    task automatic make_overlap();
        int t;
        int o;
        t = $unsigned($random(seed)) % `TREX_BOX_COUNT;
        o = $unsigned($random(seed)) % `OBSTACLE_BOX_COUNT;
        obstacle_boxes[o] = trex_boxes[t];
    endtask

    task automatic begin_test();
        fails_before = i_dut.i_runner_assertions.fail_count;
        wait_failed  = 1'b0;
    endtask

    task automatic end_test(input string name);
        int fails;
        fails = i_dut.i_runner_assertions.fail_count - fails_before;
        if (fails != 0) begin
            fail_tests++;
            $display("mismatch at %0t: %s, %0d assertion failures", $time, name, fails);
        end else if (wait_failed) begin
            fail_tests++;
            $display("failed: %s, the DUT never reached the expected state", name);
        end else begin
            pass_tests++;
            $display("pass: %s", name);
        end
    endtask

    initial begin
        jumping          = 1'b0;
        painter_finished = 1'b0;
        invert_trigger   = 1'b0;
        draw_disjoint_boxes();
        wait (rst === 1'b0);
        tick();

        begin_test();
        jumping = 1'b1;
        repeat (6) tick();
        jumping = 1'b0;
        tick();
        end_test("reset and jump without a frame");

        begin_test();
        frames_on = 1'b1;
        jumping   = 1'b1;
        wait_state(RUNNING, 3 * FRAME_CYCLES);
        jumping = 1'b0;
        run_frames(`CLEAR_TIME + 4);
        end_test("start and speed ramp");

        // Enough frames for the rise, the full inversion and the fall
        begin_test();
        invert_trigger = 1'b1;
        run_frames(1);
        invert_trigger = 1'b0;
        run_frames(`INVERT_FADE_DURATION + 60);
        end_test("night mode fade");

        // Night still fading in when the crash and the restart come
        begin_test();
        invert_trigger = 1'b1;
        run_frames(1);
        invert_trigger = 1'b0;
        repeat (8) begin
            draw_disjoint_boxes();
            run_frames(1);
        end
        make_overlap();
        wait_state(CRASHED, FRAME_CYCLES);
        draw_disjoint_boxes();
        run_frames(4);
        end_test("collision");

        begin_test();
        jumping = 1'b1;
        wait_state(RESTARTING, FRAME_CYCLES);
        run_frames(2);
        jumping = 1'b0;
        wait_state(WAITING, FRAME_CYCLES);
        run_frames(2);
        end_test("restart");

        $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && i_dut.i_runner_assertions.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/runner_assertions.sv
`timescale 1ns/100ps
`include "runner_defs.svh"

module runner_assertions (
    input logic                       clk,
    input logic                       rst,
    input logic                       jumping,
    input logic                       painter_finished,
    input logic                       invert_trigger,
    input runner_pkg::collision_box_t trex_boxes     [`TREX_BOX_COUNT],
    input runner_pkg::collision_box_t obstacle_boxes [`OBSTACLE_BOX_COUNT],
    input runner_pkg::game_state_t    state,
    input runner_pkg::speed_t         speed,
    input logic                       has_obstacles,
    input logic [7:0]                 night_rate
);
    import runner_pkg::*;

    int   fail_count = 0;
    int   run_frames;
    int   fade_frames;
    logic painter_last;
    logic frame;
    logic jumping_last;
    logic hit_last;
    logic night_on;
    logic any_hit;
    logic jump_edge;
    logic run_step;
    logic restart_step;

    function automatic logic boxes_overlap(input collision_box_t a, input collision_box_t b);
        if (a.w == '0 || a.h == '0 || b.w == '0 || b.h == '0) begin
            return 1'b0;
        end
        return int'(a.x) < int'(b.x) + int'(b.w) && int'(b.x) < int'(a.x) + int'(a.w)
            && int'(a.y) < int'(b.y) + int'(b.h) && int'(b.y) < int'(a.y) + int'(a.h);
    endfunction

    // Speed after one running frame, clamped at the ceiling
    function automatic speed_t ramped(input speed_t s);
        return (int'(s) + `ACCELERATION > `MAX_SPEED) ? s : speed_t'(int'(s) + `ACCELERATION);
    endfunction

    task automatic count_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    always_comb begin
        any_hit = 1'b0;
        for (int t = 0; t < `TREX_BOX_COUNT; t++) begin
            for (int o = 0; o < `OBSTACLE_BOX_COUNT; o++) begin
                any_hit |= boxes_overlap(trex_boxes[t], obstacle_boxes[o]);
            end
        end
    end

    assign jump_edge    = jumping && !jumping_last;
    assign run_step     = frame && state == RUNNING && !hit_last;
    assign restart_step = (state == CRASHED && jump_edge) || (state == RESTARTING && jumping);

    // Expected frame step, crash flag, running frames and inversion
    always_ff @(posedge clk) begin
        if (rst) begin
            painter_last <= 1'b0;
            frame        <= 1'b0;
            jumping_last <= 1'b0;
            hit_last     <= 1'b0;
            night_on     <= 1'b0;
            fade_frames  <= 0;
            run_frames   <= 0;
        end else begin
            painter_last <= painter_finished;
            frame        <= painter_finished && !painter_last;
            jumping_last <= jumping;
            hit_last     <= any_hit;
            if (restart_step) begin
                night_on    <= 1'b0;
                fade_frames <= 0;
                run_frames  <= 0;
            end else if (run_step) begin
                if (run_frames < `CLEAR_TIME + 2) begin
                    run_frames <= run_frames + 1;
                end
                // Inversion ends on the run step after the fade count is full
                if (night_on && fade_frames == `INVERT_FADE_DURATION) begin
                    night_on    <= 1'b0;
                    fade_frames <= 0;
                end else if (night_on) begin
                    fade_frames <= fade_frames + 1;
                end else if (invert_trigger) begin
                    night_on <= 1'b1;
                end
            end
        end
    end

    a_reset_values: assert property (@(posedge clk)
        $fell(rst) |-> state == WAITING && speed == '0 && night_rate == '0)
        else count_failure("state, speed or night_rate wrong after reset");

    a_wait_no_frame: assert property (@(posedge clk) disable iff (rst)
        state == WAITING && !frame |=> state == WAITING)
        else count_failure("left WAITING without a frame step");

    a_start: assert property (@(posedge clk) disable iff (rst)
        state == WAITING && frame && jumping |=> state == RUNNING && speed == `SPEED_INIT)
        else count_failure("jump on a frame did not start at the initial speed");

    a_speed_ramp: assert property (@(posedge clk) disable iff (rst)
        run_step |=> speed == ramped($past(speed)))
        else count_failure("speed did not step by the acceleration");

    a_speed_idle: assert property (@(posedge clk) disable iff (rst)
        state == RUNNING && !frame |=> $stable(speed))
        else count_failure("speed changed between frames");

    a_obstacles_low: assert property (@(posedge clk) disable iff (rst)
        run_frames <= `CLEAR_TIME |-> !has_obstacles)
        else count_failure("has_obstacles rose before the clear time");

    a_obstacles_high: assert property (@(posedge clk) disable iff (rst)
        run_frames >= `CLEAR_TIME + 2 |-> has_obstacles)
        else count_failure("has_obstacles still low after the clear time");

    a_keep_running: assert property (@(posedge clk) disable iff (rst)
        state == RUNNING && !hit_last |=> state == RUNNING)
        else count_failure("left RUNNING without an overlap");

    a_crash_latency: assert property (@(posedge clk) disable iff (rst)
        state == RUNNING && any_hit |-> ##2 state == CRASHED)
        else count_failure("overlap did not reach CRASHED two cycles later");

    a_crash_speed: assert property (@(posedge clk) disable iff (rst)
        state == CRASHED && !jump_edge |=> $stable(speed))
        else count_failure("speed moved while crashed");

    a_restart_entry: assert property (@(posedge clk) disable iff (rst)
        state == CRASHED && jump_edge |=> state == RESTARTING)
        else count_failure("jump edge while crashed did not restart");

    a_restart_clear: assert property (@(posedge clk) disable iff (rst)
        state == RESTARTING |-> speed == '0 && !has_obstacles && night_rate == '0)
        else count_failure("speed, has_obstacles or night_rate not cleared on restart");

    a_restart_exit: assert property (@(posedge clk) disable iff (rst)
        state == RESTARTING && !jumping |=> state == WAITING)
        else count_failure("jump release did not return to WAITING");

    a_night_rise: assert property (@(posedge clk) disable iff (rst)
        frame && !restart_step && night_on && night_rate < 8'(`MAX_NIGHT_RATE)
        |=> night_rate == 8'($past(night_rate) + `NIGHT_RATE_DELTA))
        else count_failure("night_rate did not rise by one step");

    a_night_fall: assert property (@(posedge clk) disable iff (rst)
        frame && !restart_step && !night_on && night_rate > 8'd0
        |=> night_rate == 8'($past(night_rate) - `NIGHT_RATE_DELTA))
        else count_failure("night_rate did not fall by one step");

    // Full night holds at the ceiling and day holds at zero
    a_night_hold: assert property (@(posedge clk) disable iff (rst)
        frame && !restart_step
        && night_rate == (night_on ? 8'(`MAX_NIGHT_RATE) : 8'd0)
        |=> $stable(night_rate))
        else count_failure("night_rate moved past its limit");

    a_night_idle: assert property (@(posedge clk) disable iff (rst)
        !frame && !restart_step |=> $stable(night_rate))
        else count_failure("night_rate changed between frames");

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: hdl/runner_top.sv
`timescale 1ns/100ps
`include "runner_defs.svh"

module runner_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       jumping,
    input  logic                       painter_finished,
    input  logic                       invert_trigger,
    input  runner_pkg::collision_box_t trex_boxes     [`TREX_BOX_COUNT],
    input  runner_pkg::collision_box_t obstacle_boxes [`OBSTACLE_BOX_COUNT],
    output runner_pkg::game_state_t    state,
    output runner_pkg::speed_t         speed,
    output logic                       has_obstacles,
    output logic [7:0]                 night_rate
);

    logic crashed;

    game_ctrl_if ctrl ();

    game_fsm i_game_fsm (
        .clk              (clk),
        .rst              (rst),
        .jumping          (jumping),
        .painter_finished (painter_finished),
        .crashed          (crashed),
        .ctrl             (ctrl.fsm),
        .state            (state)
    );

    box_collider i_box_collider (
        .clk            (clk),
        .rst            (rst),
        .trex_boxes     (trex_boxes),
        .obstacle_boxes (obstacle_boxes),
        .crashed        (crashed)
    );

    speed_ctrl i_speed_ctrl (
        .clk           (clk),
        .rst           (rst),
        .ctrl          (ctrl.follower),
        .speed         (speed),
        .has_obstacles (has_obstacles)
    );

    night_mode i_night_mode (
        .clk            (clk),
        .rst            (rst),
        .ctrl           (ctrl.follower),
        .invert_trigger (invert_trigger),
        .night_rate     (night_rate)
    );

endmodule

// File: hdl/night_mode.sv
`timescale 1ns/100ps
`include "runner_defs.svh"

module night_mode (
    input  logic          clk,
    input  logic          rst,
    game_ctrl_if.follower ctrl,
    input  logic          invert_trigger,
    output logic [7:0]    night_rate
);
    localparam int FADE_WIDTH = $clog2(`INVERT_FADE_DURATION + 1);

    logic                  inverted;
    logic [FADE_WIDTH-1:0] invert_timer;

    // Inversion flag and its lifetime in running frames
    always_ff @(posedge clk) begin
        if (rst) begin
            inverted     <= 1'b0;
            invert_timer <= '0;
        end else if (ctrl.restart) begin
            inverted     <= 1'b0;
            invert_timer <= '0;
        end else if (ctrl.run_step) begin
            if (invert_timer == FADE_WIDTH'(`INVERT_FADE_DURATION)) begin
                invert_timer <= '0;
                inverted     <= 1'b0;
            end else if (inverted) begin
                invert_timer <= invert_timer + 1'b1;
            end else if (invert_trigger) begin
                inverted <= 1'b1;
            end
        end
    end

    // Fade toward full night or back to day
    always_ff @(posedge clk) begin
        if (rst) begin
            night_rate <= '0;
        end else if (ctrl.restart) begin
            night_rate <= '0;
        end else if (ctrl.update) begin
            if (inverted && night_rate < 8'(`MAX_NIGHT_RATE)) begin
                night_rate <= night_rate + 8'(`NIGHT_RATE_DELTA);
            end else if (!inverted && night_rate > 8'd0) begin
                night_rate <= night_rate - 8'(`NIGHT_RATE_DELTA);
            end
        end
    end

endmodule

// File: hdl/speed_ctrl.sv
`timescale 1ns/100ps
`include "runner_defs.svh"

module speed_ctrl (
    input  logic               clk,
    input  logic               rst,
    game_ctrl_if.follower      ctrl,
    output runner_pkg::speed_t speed,
    output logic               has_obstacles
);
    localparam int CLEAR_WIDTH = $clog2(`CLEAR_TIME + 2);

    logic [CLEAR_WIDTH-1:0]  clear_timer;
    logic [`SPEED_WIDTH:0]   speed_next;
    logic                    speed_room;

    // One extra bit so the ceiling test cannot wrap
    assign speed_next = {1'b0, speed} + (`SPEED_WIDTH+1)'(`ACCELERATION);
    assign speed_room = speed_next <= (`SPEED_WIDTH+1)'(`MAX_SPEED);

    always_ff @(posedge clk) begin
        if (rst) begin
            speed <= '0;
        end else if (ctrl.restart) begin
            speed <= '0;
        end else if (ctrl.init_pulse) begin
            speed <= `SPEED_WIDTH'(`SPEED_INIT);
        end else if (ctrl.run_step && speed_room) begin
            speed <= speed_next[`SPEED_WIDTH-1:0];
        end
    end

    // Obstacles only after the clear time has elapsed
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_timer   <= '0;
            has_obstacles <= 1'b0;
        end else if (ctrl.restart) begin
            clear_timer   <= '0;
            has_obstacles <= 1'b0;
        end else if (ctrl.run_step && !has_obstacles) begin
            clear_timer <= clear_timer + 1'b1;
            if (clear_timer > CLEAR_WIDTH'(`CLEAR_TIME)) begin
                has_obstacles <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/box_collider.sv
`timescale 1ns/100ps
`include "runner_defs.svh"

module box_collider (
    input  logic                       clk,
    input  logic                       rst,
    input  runner_pkg::collision_box_t trex_boxes     [`TREX_BOX_COUNT],
    input  runner_pkg::collision_box_t obstacle_boxes [`OBSTACLE_BOX_COUNT],
    output logic                       crashed
);
    import runner_pkg::*;

    logic hit;

    // Strict overlap on both axes, empty boxes never hit
    function automatic logic overlap(input collision_box_t a, input collision_box_t b);
        logic [`COORD_WIDTH:0] a_x_end;
        logic [`COORD_WIDTH:0] a_y_end;
        logic [`COORD_WIDTH:0] b_x_end;
        logic [`COORD_WIDTH:0] b_y_end;
        logic                  empty;
        a_x_end = {1'b0, a.x} + {1'b0, a.w};
        a_y_end = {1'b0, a.y} + {1'b0, a.h};
        b_x_end = {1'b0, b.x} + {1'b0, b.w};
        b_y_end = {1'b0, b.y} + {1'b0, b.h};
        empty   = (a.w == '0) || (a.h == '0) || (b.w == '0) || (b.h == '0);
        return !empty
            && ({1'b0, a.x} < b_x_end) && ({1'b0, b.x} < a_x_end)
            && ({1'b0, a.y} < b_y_end) && ({1'b0, b.y} < a_y_end);
    endfunction

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < `TREX_BOX_COUNT; i++) begin
            for (int j = 0; j < `OBSTACLE_BOX_COUNT; j++) begin
                hit |= overlap(trex_boxes[i], obstacle_boxes[j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crashed <= 1'b0;
        end else begin
            crashed <= hit;
        end
    end

endmodule

// File: hdl/game_fsm.sv
`timescale 1ns/100ps

module game_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    jumping,
    input  logic                    painter_finished,
    input  logic                    crashed,
    game_ctrl_if.fsm                ctrl,
    output runner_pkg::game_state_t state
);
    import runner_pkg::*;

    game_state_t next_state;

    logic painter_finished_last;
    logic jumping_last;
    logic update;
    logic jump_edge;

    assign jump_edge = jumping && !jumping_last;

    always_comb begin
        next_state = state;
        case (state)
            WAITING: begin
                if (update && jumping) begin
                    next_state = RUNNING;
                end
            end
            RUNNING: begin
                if (crashed) begin
                    next_state = CRASHED;
                end
            end
            CRASHED: begin
                // A fresh jump press restarts the game
                if (jump_edge) begin
                    next_state = RESTARTING;
                end
            end
            RESTARTING: begin
                // Hold here until the jump is released
                if (!jumping) begin
                    next_state = WAITING;
                end
            end
            default: begin
                next_state = WAITING;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                 <= WAITING;
            update                <= 1'b0;
            painter_finished_last <= 1'b0;
            jumping_last          <= 1'b0;
        end else begin
            state                 <= next_state;
            painter_finished_last <= painter_finished;
            jumping_last          <= jumping;
            // Rising edge of painter_finished steps the game loop
            update                <= painter_finished && !painter_finished_last;
        end
    end

    assign ctrl.update     = update;
    assign ctrl.init_pulse = update && (state == WAITING) && (next_state == RUNNING);
    assign ctrl.run_step   = update && (state == RUNNING) && (next_state == RUNNING);
    assign ctrl.restart    = (next_state == RESTARTING);

endmodule

// File: hdl/game_ctrl_if.sv
`timescale 1ns/100ps

interface game_ctrl_if;

    // Frame step, one cycle per painted frame
    logic update;
    // Waiting to running transition
    logic init_pulse;
    // Frame step while staying in running
    logic run_step;
    // Level while heading into restarting
    logic restart;

    modport fsm (
        output update,
        output init_pulse,
        output run_step,
        output restart
    );

    modport follower (
        input update,
        input init_pulse,
        input run_step,
        input restart
    );

endinterface

// File: hdl/runner_pkg.sv
`include "runner_defs.svh"

package runner_pkg;

    // Top level game phase
    typedef enum logic [1:0] {
        WAITING,
        RUNNING,
        CRASHED,
        RESTARTING
    } game_state_t;

    // Axis aligned box, origin at top left
    typedef struct packed {
        logic [`COORD_WIDTH-1:0] x;
        logic [`COORD_WIDTH-1:0] y;
        logic [`COORD_WIDTH-1:0] w;
        logic [`COORD_WIDTH-1:0] h;
    } collision_box_t;

    typedef logic [`SPEED_WIDTH-1:0] speed_t;

endpackage

// File: include/runner_defs.svh
`ifndef RUNNER_DEFS_SVH
`define RUNNER_DEFS_SVH

// Frame rate of the game loop
`define FPS 60

// Running frames before obstacles appear
`define CLEAR_TIME (3 * `FPS)

// Speed in units of 1/1024 pixel per frame
`define SPEED_INIT 6144
`define MAX_SPEED 13312
`define ACCELERATION 1
`define SPEED_WIDTH 15

// Night mode fade
`define INVERT_FADE_DURATION 720
`define MAX_NIGHT_RATE 255
`define NIGHT_RATE_DELTA 5

// Collision boxes
`define TREX_BOX_COUNT 3
`define OBSTACLE_BOX_COUNT 3
`define COORD_WIDTH 12

`endif
